// ==== lcd_controller.f ====
source/lcd_pkg.sv
source/lcd_bus_timer.sv
source/lcd_command_fsm.sv
source/lcd_pixel_fifo.sv
source/lcd_data_writer.sv
source/lcd_controller.sv
testbench/lcd_panel_model.sv
testbench/tb_lcd_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_lcd_controller \
  -f lcd_controller.f \
  -o sim_lcd_controller

./obj_dir/sim_lcd_controller | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== source/lcd_bus_timer.sv ====
`timescale 1ns/1ps

module lcd_bus_timer #(
  parameter int STROBE_CYCLES = 2
)(
  input  logic              i_clk,
  input  logic              i_reset,
  input  lcd_pkg::lcd_xfer_t i_xfer,
  input  logic [7:0]        i_data_in,
  output lcd_pkg::lcd_pins_t o_pins,
  output logic              o_done,
  output logic [7:0]        o_rd_data
);

  localparam int CW = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

  lcd_pkg::lcd_xfer_t req;
  logic               busy;
  logic               phase_high;
  logic [CW-1:0]      cnt;
  logic               strobe;
  logic               last_cycle;

  assign last_cycle = (cnt == CW'(STROBE_CYCLES - 1));
  assign strobe     = busy && !phase_high;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy       <= 1'b0;
      phase_high <= 1'b0;
      cnt        <= '0;
      o_done     <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (!busy) begin
        if (i_xfer.start) begin
          busy       <= 1'b1;
          phase_high <= 1'b0;
          cnt        <= '0;
        end
      end else if (last_cycle) begin
        cnt <= '0;
        if (phase_high) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end else begin
          phase_high <= 1'b1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Latched request and captured read byte
  always_ff @(posedge i_clk) begin
    if (!busy && i_xfer.start)
      req <= i_xfer;
    // Sample on the last low cycle of a read strobe
    if (strobe && last_cycle && req.read)
      o_rd_data <= i_data_in;
  end

  assign o_pins.dc      = req.dc;
  assign o_pins.write_n = !(strobe && !req.read);
  assign o_pins.read_n  = !(strobe && req.read);
  assign o_pins.data_oe = busy && !req.read;
  assign o_pins.data    = req.data;

endmodule

// ==== source/lcd_command_fsm.sv ====
`timescale 1ns/1ps

module lcd_command_fsm (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_enable,
  input  logic               i_cmd_parameter,
  input  logic               i_cmd_write_stb,
  input  logic               i_cmd_read_stb,
  input  logic [7:0]         i_cmd_data,
  input  logic               i_done,
  input  logic [7:0]         i_rd_data,
  output lcd_pkg::lcd_xfer_t o_xfer,
  output logic [7:0]         o_cmd_data,
  output logic               o_cmd_finished
);

  lcd_pkg::cmd_state_e state;
  logic                accept;
  logic                is_read;

  // Strobe goes straight to the bus engine from idle
  assign accept = (state == lcd_pkg::CMD_IDLE) && i_enable &&
                  (i_cmd_write_stb || i_cmd_read_stb);

  assign o_xfer.start = accept;
  assign o_xfer.read  = i_cmd_read_stb;
  assign o_xfer.dc    = i_cmd_parameter;
  assign o_xfer.data  = i_cmd_data;

  assign o_cmd_finished = (state == lcd_pkg::CMD_DONE);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= lcd_pkg::CMD_IDLE;
    end else begin
      case (state)
        lcd_pkg::CMD_IDLE: begin
          if (accept)
            state <= lcd_pkg::CMD_XFER;
        end
        lcd_pkg::CMD_XFER: begin
          if (i_done)
            state <= lcd_pkg::CMD_DONE;
        end
        lcd_pkg::CMD_DONE: begin
          state <= lcd_pkg::CMD_IDLE;
        end
        default: begin
          state <= lcd_pkg::CMD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept)
      is_read <= i_cmd_read_stb;
    // Read byte holds until the next read
    if ((state == lcd_pkg::CMD_XFER) && i_done && is_read)
      o_cmd_data <= i_rd_data;
  end

endmodule

// ==== source/lcd_controller.sv ====
`timescale 1ns/1ps

module lcd_controller #(
  parameter int STROBE_CYCLES = 2,
  parameter int BUFFER_DEPTH  = 16
)(
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_enable,
  input  logic                          i_reset_display,
  input  logic                          i_data_command_mode,
  input  logic                          i_enable_tearing,
  input  logic                          i_frame_start,
  input  logic [31:0]                   i_num_pixels,
  input  logic                          i_cmd_parameter,
  input  logic                          i_cmd_write_stb,
  input  logic                          i_cmd_read_stb,
  input  logic [7:0]                    i_cmd_data,
  output logic [7:0]                    o_cmd_data,
  output logic                          o_cmd_finished,
  input  logic                          i_backlight_enable,
  input  logic                          i_chip_select,
  input  logic                          i_fifo_stb,
  input  logic [23:0]                   i_fifo_data,
  output logic                          o_fifo_full,
  output logic [$clog2(BUFFER_DEPTH):0] o_fifo_count,
  output logic                          o_frame_done,
  output logic                          o_backlight_enable,
  output logic                          o_register_data_sel,
  output logic                          o_write_n,
  output logic                          o_read_n,
  output logic [7:0]                    o_data,
  output logic                          o_data_oe,
  input  logic [7:0]                    i_data,
  output logic                          o_cs_n,
  output logic                          o_reset_n,
  input  logic                          i_tearing_effect,
  output logic                          o_display_on
);

  localparam int PIXEL_WIDTH = 24;

  lcd_pkg::lcd_xfer_t     cmd_xfer;
  lcd_pkg::lcd_xfer_t     wr_xfer;
  lcd_pkg::lcd_xfer_t     bus_xfer;
  lcd_pkg::lcd_pins_t     pins;
  logic                   bus_done;
  logic [7:0]             bus_rd_data;
  logic                   fifo_empty;
  logic                   fifo_pop;
  logic [PIXEL_WIDTH-1:0] fifo_head;

  lcd_command_fsm cmd0 (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_enable        (i_enable),
    .i_cmd_parameter (i_cmd_parameter),
    .i_cmd_write_stb (i_cmd_write_stb),
    .i_cmd_read_stb  (i_cmd_read_stb),
    .i_cmd_data      (i_cmd_data),
    .i_done          (bus_done && !i_data_command_mode),
    .i_rd_data       (bus_rd_data),
    .o_xfer          (cmd_xfer),
    .o_cmd_data      (o_cmd_data),
    .o_cmd_finished  (o_cmd_finished)
  );

  lcd_data_writer writer0 (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_enable         (i_enable),
    .i_frame_start    (i_frame_start),
    .i_enable_tearing (i_enable_tearing),
    .i_tearing_effect (i_tearing_effect),
    .i_num_pixels     (i_num_pixels),
    .i_fifo_empty     (fifo_empty),
    .i_fifo_data      (fifo_head),
    .i_done           (bus_done && i_data_command_mode),
    .o_fifo_pop       (fifo_pop),
    .o_xfer           (wr_xfer),
    .o_frame_done     (o_frame_done)
  );

  lcd_pixel_fifo #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) fifo0 (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_push      (i_fifo_stb),
    .i_push_data (i_fifo_data),
    .i_pop       (fifo_pop),
    .o_pop_data  (fifo_head),
    .o_empty     (fifo_empty),
    .o_full      (o_fifo_full),
    .o_count     (o_fifo_count)
  );

  // Mode level picks the bus owner
  assign bus_xfer = i_data_command_mode ? wr_xfer : cmd_xfer;

  lcd_bus_timer #(
    .STROBE_CYCLES (STROBE_CYCLES)
  ) bus0 (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_xfer    (bus_xfer),
    .i_data_in (i_data),
    .o_pins    (pins),
    .o_done    (bus_done),
    .o_rd_data (bus_rd_data)
  );

  assign o_register_data_sel = pins.dc;
  assign o_write_n           = pins.write_n;
  assign o_read_n            = pins.read_n;
  assign o_data_oe           = pins.data_oe;
  assign o_data              = pins.data;

  assign o_cs_n             = ~i_chip_select;
  assign o_reset_n          = ~i_reset_display;
  assign o_backlight_enable = i_backlight_enable;
  assign o_display_on       = i_enable;

endmodule

// ==== source/lcd_data_writer.sv ====
`timescale 1ns/1ps

module lcd_data_writer (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_enable,
  input  logic               i_frame_start,
  input  logic               i_enable_tearing,
  input  logic               i_tearing_effect,
  input  logic [31:0]        i_num_pixels,
  input  logic               i_fifo_empty,
  input  logic [23:0]        i_fifo_data,
  input  logic               i_done,
  output logic               o_fifo_pop,
  output lcd_pkg::lcd_xfer_t o_xfer,
  output logic               o_frame_done
);

  lcd_pkg::wr_state_e state;
  logic               frame_q;
  logic               te_q;
  logic               frame_rise;
  logic               te_rise;
  logic               pending;
  logic               sending;
  logic [31:0]        remaining;
  logic [1:0]         byte_idx;
  logic [23:0]        shift;

  assign frame_rise = i_frame_start && !frame_q;
  assign te_rise    = i_tearing_effect && !te_q;
  assign sending    = (state == lcd_pkg::WR_SEND_OP) || (state == lcd_pkg::WR_SEND_BYTE);

  assign o_xfer.start = sending && !pending;
  assign o_xfer.read  = 1'b0;
  assign o_xfer.dc    = (state != lcd_pkg::WR_SEND_OP);
  assign o_xfer.data  = (state == lcd_pkg::WR_SEND_OP) ? lcd_pkg::MEM_WRITE : shift[23:16];

  assign o_fifo_pop   = (state == lcd_pkg::WR_LOAD) && i_enable && !i_fifo_empty;
  assign o_frame_done = (state == lcd_pkg::WR_DONE);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state   <= lcd_pkg::WR_IDLE;
      frame_q <= 1'b0;
      te_q    <= 1'b0;
      pending <= 1'b0;
    end else begin
      frame_q <= i_frame_start;
      te_q    <= i_tearing_effect;
      if (o_xfer.start)
        pending <= 1'b1;
      else if (i_done)
        pending <= 1'b0;

      case (state)
        lcd_pkg::WR_IDLE: begin
          if (i_enable && frame_rise)
            state <= i_enable_tearing ? lcd_pkg::WR_WAIT_TE : lcd_pkg::WR_SEND_OP;
        end
        lcd_pkg::WR_WAIT_TE: begin
          if (!i_enable)
            state <= lcd_pkg::WR_IDLE;
          else if (te_rise)
            state <= lcd_pkg::WR_SEND_OP;
        end
        lcd_pkg::WR_SEND_OP: begin
          if (i_done) begin
            if (!i_enable)
              state <= lcd_pkg::WR_IDLE;
            else
              state <= (remaining == '0) ? lcd_pkg::WR_DONE : lcd_pkg::WR_LOAD;
          end
        end
        lcd_pkg::WR_LOAD: begin
          // Stall here while the FIFO is empty
          if (!i_enable)
            state <= lcd_pkg::WR_IDLE;
          else if (!i_fifo_empty)
            state <= lcd_pkg::WR_SEND_BYTE;
        end
        lcd_pkg::WR_SEND_BYTE: begin
          if (i_done) begin
            if (!i_enable)
              state <= lcd_pkg::WR_IDLE;
            else if (byte_idx == 2'd2)
              state <= (remaining == 32'd1) ? lcd_pkg::WR_DONE : lcd_pkg::WR_LOAD;
          end
        end
        lcd_pkg::WR_DONE: begin
          state <= lcd_pkg::WR_IDLE;
        end
        default: begin
          state <= lcd_pkg::WR_IDLE;
        end
      endcase
    end
  end

  // Pixel countdown and byte split
  always_ff @(posedge i_clk) begin
    if ((state == lcd_pkg::WR_IDLE) && frame_rise)
      remaining <= i_num_pixels;
    if (o_fifo_pop) begin
      shift    <= i_fifo_data;
      byte_idx <= 2'd0;
    end else if ((state == lcd_pkg::WR_SEND_BYTE) && i_done) begin
      shift    <= {shift[15:0], 8'h00};
      byte_idx <= byte_idx + 2'd1;
      if (byte_idx == 2'd2)
        remaining <= remaining - 32'd1;
    end
  end

endmodule

// ==== source/lcd_pixel_fifo.sv ====
`timescale 1ns/1ps

module lcd_pixel_fifo #(
  parameter int BUFFER_DEPTH = 16
)(
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_push,
  input  logic [23:0]                   i_push_data,
  input  logic                          i_pop,
  output logic [23:0]                   o_pop_data,
  output logic                          o_empty,
  output logic                          o_full,
  output logic [$clog2(BUFFER_DEPTH):0] o_count
);

  localparam int PIXEL_WIDTH = 24;
  localparam int AW          = $clog2(BUFFER_DEPTH);

  logic [PIXEL_WIDTH-1:0] mem [BUFFER_DEPTH];
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  logic                   push_ok;
  logic                   pop_ok;

  assign o_empty = (o_count == '0);
  assign o_full  = (o_count == (AW + 1)'(BUFFER_DEPTH));
  // Pushes while full are dropped
  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  assign o_pop_data = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (push_ok)
      mem[wr_ptr] <= i_push_data;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      if (push_ok && !pop_ok)
        o_count <= o_count + 1'b1;
      else if (pop_ok && !push_ok)
        o_count <= o_count - 1'b1;
    end
  end

endmodule

// ==== source/lcd_pkg.sv ====
package lcd_pkg;

  // One request from a master to the bus engine
  typedef struct packed {
    logic       start;
    logic       read;
    logic       dc;
    logic [7:0] data;
  } lcd_xfer_t;

  // Panel side of the 8080 bus
  typedef struct packed {
    logic       dc;
    logic       write_n;
    logic       read_n;
    logic       data_oe;
    logic [7:0] data;
  } lcd_pins_t;

  typedef enum logic [7:0] {
    NOP         = 8'h00,
    SOFT_RESET  = 8'h01,
    SLEEP_OUT   = 8'h11,
    DISPLAY_ON  = 8'h29,
    COLUMN_SET  = 8'h2A,
    PAGE_SET    = 8'h2B,
    MEM_WRITE   = 8'h2C
  } lcd_opcode_e;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_XFER,
    CMD_DONE
  } cmd_state_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT_TE,
    WR_SEND_OP,
    WR_LOAD,
    WR_SEND_BYTE,
    WR_DONE
  } wr_state_e;

endpackage

// ==== testbench/lcd_panel_model.sv ====
`timescale 1ns/1ps

module lcd_panel_model (
  input  logic       i_reset,
  input  logic       i_write_n,
  input  logic       i_read_n,
  input  logic       i_dc,
  input  logic [7:0] i_data,
  output logic [7:0] o_data
);

  // Each entry is {dc, byte}
  logic [8:0] log_q[$];
  logic [7:0] last_cmd = 8'h00;

  // Panel latches the bus on the rising edge of WR#
  always @(posedge i_write_n) begin
    if (!i_reset) begin
      log_q.push_back({i_dc, i_data});
      if (!i_dc)
        last_cmd <= i_data;
    end
  end

  // Read answer is the inverse of the last command byte
  assign o_data = !i_read_n ? ~last_cmd : 8'h00;

endmodule

// ==== testbench/tb_lcd_controller.sv ====
`timescale 1ns/1ps

module tb_lcd_controller;

  localparam int CLK_PERIOD = 20;
  localparam int STROBE     = 2;
  localparam int DEPTH      = 16;
  // 136 bus transfers, 44 pushes and the fixed waits
  localparam int EST_CYCLES = 136 * (2 * STROBE + 2) + 44 + 60;

  logic        i_clk = 1'b0;
  logic        i_reset, i_enable, i_reset_display, i_data_command_mode;
  logic        i_enable_tearing, i_frame_start, i_tearing_effect;
  logic [31:0] i_num_pixels;
  logic        i_cmd_parameter, i_cmd_write_stb, i_cmd_read_stb;
  logic [7:0]  i_cmd_data, o_cmd_data, o_data, panel_data;
  logic        o_cmd_finished, i_backlight_enable, i_chip_select, i_fifo_stb;
  logic [23:0] i_fifo_data;
  logic        o_fifo_full, o_frame_done, o_backlight_enable, o_register_data_sel;
  logic [4:0]  o_fifo_count;
  logic        o_write_n, o_read_n, o_data_oe, o_cs_n, o_reset_n, o_display_on;

  logic        te_wait = 1'b0;
  logic        fifo_stall = 1'b0;
  logic [23:0] exp_q[$];
  int          seed = 32'h0240_d497;
  int          err_count = 0;
  int          errs_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          rx_idx = 0;
  int          frame_done_cnt = 0;

  lcd_controller #(
    .STROBE_CYCLES (STROBE),
    .BUFFER_DEPTH  (DEPTH)
  ) dut0 (
    .i_clk               (i_clk),
    .i_reset             (i_reset),
    .i_enable            (i_enable),
    .i_reset_display     (i_reset_display),
    .i_data_command_mode (i_data_command_mode),
    .i_enable_tearing    (i_enable_tearing),
    .i_frame_start       (i_frame_start),
    .i_num_pixels        (i_num_pixels),
    .i_cmd_parameter     (i_cmd_parameter),
    .i_cmd_write_stb     (i_cmd_write_stb),
    .i_cmd_read_stb      (i_cmd_read_stb),
    .i_cmd_data          (i_cmd_data),
    .o_cmd_data          (o_cmd_data),
    .o_cmd_finished      (o_cmd_finished),
    .i_backlight_enable  (i_backlight_enable),
    .i_chip_select       (i_chip_select),
    .i_fifo_stb          (i_fifo_stb),
    .i_fifo_data         (i_fifo_data),
    .o_fifo_full         (o_fifo_full),
    .o_fifo_count        (o_fifo_count),
    .o_frame_done        (o_frame_done),
    .o_backlight_enable  (o_backlight_enable),
    .o_register_data_sel (o_register_data_sel),
    .o_write_n           (o_write_n),
    .o_read_n            (o_read_n),
    .o_data              (o_data),
    .o_data_oe           (o_data_oe),
    .i_data              (panel_data),
    .o_cs_n              (o_cs_n),
    .o_reset_n           (o_reset_n),
    .i_tearing_effect    (i_tearing_effect),
    .o_display_on        (o_display_on)
  );

  lcd_panel_model panel0 (
    .i_reset   (i_reset),
    .i_write_n (o_write_n),
    .i_read_n  (o_read_n),
    .i_dc      (o_register_data_sel),
    .i_data    (o_data),
    .o_data    (panel_data)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  always @(posedge i_clk) begin
    if (o_frame_done)
      frame_done_cnt <= frame_done_cnt + 1;
  end

  assert property (@(posedge i_clk) disable iff (i_reset) !o_write_n |-> o_data_oe)
    else begin
      $display("ERR %0t: data_oe low during a write strobe", $time);
      err_count++;
    end

  assert property (@(posedge i_clk) disable iff (i_reset) !o_read_n |-> o_write_n)
    else begin
      $display("ERR %0t: write strobe during a read", $time);
      err_count++;
    end

  assert property (@(posedge i_clk) disable iff (i_reset) te_wait |-> o_write_n)
    else begin
      $display("ERR %0t: write strobe before tearing edge", $time);
      err_count++;
    end

  assert property (@(posedge i_clk) disable iff (i_reset) fifo_stall |-> o_write_n)
    else begin
      $display("ERR %0t: write strobe while the FIFO is empty", $time);
      err_count++;
    end

  // Inputs move 2 ns after the rising edge
  task automatic tick();
    @(posedge i_clk);
    #2;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (err_count == errs_at_start) begin
      $display("[%0d] %s: ok", tests_run, name);
    end else begin
      $display("[%0d] %s: %0d errors", tests_run, name, err_count - errs_at_start);
      tests_failed++;
    end
    errs_at_start = err_count;
  endtask

  task automatic compare_static_pins(input logic cs_n, input logic reset_n,
                                     input logic backlight, input logic display_on);
    assert (o_cs_n == cs_n && o_reset_n == reset_n &&
            o_backlight_enable == backlight && o_display_on == display_on)
      else begin
        $display("ERR %0t: pins cs_n/reset_n/backlight/display_on %b%b%b%b, expected %b%b%b%b",
                 $time, o_cs_n, o_reset_n, o_backlight_enable, o_display_on,
                 cs_n, reset_n, backlight, display_on);
        err_count++;
      end
  endtask

  task automatic send_command(input logic param, input logic [7:0] data,
                              input logic rd, input logic [7:0] exp_rd);
    int n;
    i_cmd_parameter = param;
    i_cmd_data      = data;
    i_cmd_write_stb = !rd;
    i_cmd_read_stb  = rd;
    tick();
    i_cmd_write_stb = 1'b0;
    i_cmd_read_stb  = 1'b0;
    n = 1;
    while (!o_cmd_finished && n < 40) begin
      tick();
      n++;
    end
    assert (n == 2 * STROBE + 2)
      else begin
        $display("ERR %0t: cmd_finished after %0d cycles, expected %0d",
                 $time, n, 2 * STROBE + 2);
        err_count++;
      end
    if (rd) begin
      assert (o_cmd_data == exp_rd)
        else begin
          $display("ERR %0t: read byte %h, expected %h", $time, o_cmd_data, exp_rd);
          err_count++;
        end
    end
    tick();
    assert (!o_cmd_finished)
      else begin
        $display("ERR %0t: cmd_finished longer than one cycle", $time);
        err_count++;
      end
  endtask

  task automatic expect_byte(input logic dc, input logic [7:0] data);
    assert (rx_idx < panel0.log_q.size())
      else begin
        $display("Panel recorded fewer bytes than expected at %0t", $time);
        err_count++;
      end
    if (rx_idx < panel0.log_q.size()) begin
      assert (panel0.log_q[rx_idx] == {dc, data})
        else begin
          $display("ERR %0t: byte %0d is dc=%b %h, expected dc=%b %h", $time, rx_idx,
                   panel0.log_q[rx_idx][8], panel0.log_q[rx_idx][7:0], dc, data);
          err_count++;
        end
    end
    rx_idx++;
  endtask

  task automatic push_pixel(input logic [23:0] px);
    i_fifo_data = px;
    i_fifo_stb  = 1'b1;
    tick();
    i_fifo_stb  = 1'b0;
  endtask

  task automatic fill_pixels(input int n);
    logic [23:0] px;
    for (int i = 0; i < n; i++) begin
      while (o_fifo_full)
        tick();
      px = 24'($random(seed));
      exp_q.push_back(px);
      push_pixel(px);
    end
  endtask

  task automatic start_frame(input int n);
    i_num_pixels  = n;
    i_frame_start = 1'b1;
    tick();
    i_frame_start = 1'b0;
  endtask

  task automatic wait_frame_done();
    int n;
    n = 0;
    while (!o_frame_done && n < 2000) begin
      tick();
      n++;
    end
    assert (o_frame_done)
      else begin
        $display("Frame did not finish within 2000 cycles at %0t", $time);
        err_count++;
      end
  endtask

  // Opcode first, then each pixel high byte to low byte
  task automatic check_frame(input int n);
    logic [23:0] px;
    expect_byte(1'b0, lcd_pkg::MEM_WRITE);
    for (int i = 0; i < n; i++) begin
      px = exp_q.pop_front();
      expect_byte(1'b1, px[23:16]);
      expect_byte(1'b1, px[15:8]);
      expect_byte(1'b1, px[7:0]);
    end
  endtask

  initial begin
    #(4 * EST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    int cnt0;
    int n;
    i_reset = 1'b1;
    i_enable = 1'b0;
    i_reset_display = 1'b0;
    i_data_command_mode = 1'b0;
    i_enable_tearing = 1'b0;
    i_frame_start = 1'b0;
    i_tearing_effect = 1'b0;
    i_num_pixels = '0;
    i_cmd_parameter = 1'b0;
    i_cmd_write_stb = 1'b0;
    i_cmd_read_stb = 1'b0;
    i_cmd_data = '0;
    i_backlight_enable = 1'b0;
    i_chip_select = 1'b0;
    i_fifo_stb = 1'b0;
    i_fifo_data = '0;
    repeat (5) @(posedge i_clk);
    #2;
    i_reset = 1'b0;

    assert (o_write_n && o_read_n && !o_data_oe && !o_cmd_finished && !o_frame_done &&
            o_fifo_count == 5'd0)
      else begin
        $display("ERR %0t: outputs not idle after reset", $time);
        err_count++;
      end
    compare_static_pins(1'b1, 1'b1, 1'b0, 1'b0);
    close_test("reset state");

    i_enable = 1'b1;
    i_chip_select = 1'b1;
    i_backlight_enable = 1'b1;
    i_reset_display = 1'b1;
    tick();
    compare_static_pins(1'b0, 1'b0, 1'b1, 1'b1);
    i_reset_display = 1'b0;
    tick();
    compare_static_pins(1'b0, 1'b1, 1'b1, 1'b1);
    close_test("static pins");

    send_command(1'b0, 8'h3A, 1'b0, 8'h00);
    expect_byte(1'b0, 8'h3A);
    send_command(1'b1, 8'h55, 1'b0, 8'h00);
    expect_byte(1'b1, 8'h55);
    close_test("command write");

    send_command(1'b1, 8'h00, 1'b1, ~8'h3A);
    assert (panel0.log_q.size() == rx_idx)
      else begin
        $display("ERR %0t: panel recorded a write during the read", $time);
        err_count++;
      end
    close_test("command read");

    i_data_command_mode = 1'b1;
    fill_pixels(5);
    cnt0 = frame_done_cnt;
    start_frame(5);
    wait_frame_done();
    tick();
    tick();
    check_frame(5);
    assert (frame_done_cnt == cnt0 + 1)
      else begin
        $display("ERR %0t: frame_done pulsed %0d times", $time, frame_done_cnt - cnt0);
        err_count++;
      end
    close_test("frame without tearing");

    i_enable_tearing = 1'b1;
    fill_pixels(2);
    start_frame(2);
    te_wait = 1'b1;
    repeat (8) tick();
    te_wait = 1'b0;
    i_tearing_effect = 1'b1;
    repeat (2) tick();
    i_tearing_effect = 1'b0;
    wait_frame_done();
    check_frame(2);
    i_enable_tearing = 1'b0;
    close_test("frame with tearing");

    fill_pixels(16);
    assert (o_fifo_full && o_fifo_count == 5'd16)
      else begin
        $display("ERR %0t: full=%b count=%0d after 16 pushes", $time, o_fifo_full,
                 o_fifo_count);
        err_count++;
      end
    // This push is dropped and never reaches the panel
    push_pixel(24'hDEAD01);
    assert (o_fifo_count == 5'd16)
      else begin
        $display("ERR %0t: count %0d after push while full", $time, o_fifo_count);
        err_count++;
      end
    start_frame(16);
    wait_frame_done();
    check_frame(16);
    tick();
    start_frame(20);
    n = 0;
    while (panel0.log_q.size() <= rx_idx && n < 40) begin
      tick();
      n++;
    end
    fifo_stall = 1'b1;
    repeat (10) tick();
    fifo_stall = 1'b0;
    fill_pixels(20);
    wait_frame_done();
    check_frame(20);
    close_test("FIFO full and stall");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
